/* filelist.f */
+incdir+tests
common/renamePkg.sv
renameTable/RenameTable.sv
renameTable/TagFreeList.sv
verilog/RenameStage.sv
verilog/CommitTracker.sv
verilog/RenameUnit.sv
tests/RenameUnit_tb.sv

/* Makefile */
TOP = RenameUnit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

obj_dir/simv: filelist.f $(wildcard common/*.sv renameTable/*.sv verilog/*.sv tests/*)
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -o simv

sim: obj_dir/simv
	./obj_dir/simv | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/renameModel.svh */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Speculative and committed maps
renamePkg::tagT mSpec [32];
logic mAvail [32];
renamePkg::tagT mCom [32];
logic [renamePkg::NUM_TAGS-1:0] mSpecUsed;
logic [renamePkg::NUM_TAGS-1:0] mComUsed;

// In-flight queue, oldest at index 0
renamePkg::regIdT qId [$];
renamePkg::tagT qTag [$];
logic qDone [$];

function automatic void modelReset();
    for (int r = 0; r < 32; r++) begin
        mSpec[r] = renamePkg::TAG_NONE;
        mCom[r] = renamePkg::TAG_NONE;
        mAvail[r] = 1'b1;
    end
    mSpecUsed = '0;
    mSpecUsed[renamePkg::TAG_NONE] = 1'b1;
    mComUsed = mSpecUsed;
    qId.delete();
    qTag.delete();
    qDone.delete();
endfunction

function automatic int freeTags();
    int n;
    n = 0;
    for (int t = 0; t < renamePkg::NUM_TAGS; t++) begin
        if (!mSpecUsed[t]) begin
            n++;
        end
    end
    return n;
endfunction

function automatic logic modelStall();
    return (freeTags() < WIDTH) || ((DEPTH - qId.size()) < WIDTH);
endfunction

// Lowest tag not yet in use
function automatic renamePkg::tagT lowestFree(logic [renamePkg::NUM_TAGS-1:0] used);
    for (int t = 0; t < renamePkg::NUM_TAGS; t++) begin
        if (!used[t]) begin
            return renamePkg::tagT'(t);
        end
    end
    return renamePkg::TAG_NONE;
endfunction

`endif

/* tests/RenameUnit_tb.sv */
`timescale 1ns/1ps

module RenameUnit_tb;

    localparam int WIDTH = 2;
    localparam int NUM_WB = 2;
    localparam int DEPTH = 16;
    localparam int TEST_CYCLES = 20 + 400 + 200 + 150 + 300 + 200;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 200;

    logic clk;
    logic rst;
    logic mispred;
    logic instValid [WIDTH];
    renamePkg::regIdT srcA [WIDTH];
    renamePkg::regIdT srcB [WIDTH];
    renamePkg::regIdT dest [WIDTH];
    logic stall;
    logic wbValid [NUM_WB];
    renamePkg::regIdT wbId [NUM_WB];
    renamePkg::tagT wbTag [NUM_WB];
    logic outValid [WIDTH];
    renamePkg::tagT outSrcATag [WIDTH];
    logic outSrcAAvail [WIDTH];
    renamePkg::tagT outSrcBTag [WIDTH];
    logic outSrcBAvail [WIDTH];
    renamePkg::tagT outDestTag [WIDTH];
    logic commitValid [WIDTH];
    renamePkg::regIdT commitId [WIDTH];
    renamePkg::tagT commitTag [WIDTH];
    renamePkg::tagT commitPrevTag [WIDTH];

    `include "renameModel.svh"

    // Expected registered outputs for the next edge
    logic expValid [WIDTH];
    logic [22:0] expRename [WIDTH];
    logic expCValid [WIDTH];
    logic [18:0] expCommit [WIDTH];
    logic slotIssued [WIDTH];
    renamePkg::tagT slotTag [WIDTH];

    integer seed = 32'hb47;
    int errors = 0;
    int cycles = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int stallSeen;
    int freedSeen;
    int mispredSeen;
    int commitsSeen;

    RenameUnit #(.WIDTH(WIDTH), .NUM_WB(NUM_WB), .DEPTH(DEPTH)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic int pick(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic void lookupSrc(input renamePkg::regIdT id, input int slot,
                                      output renamePkg::tagT t, output logic a);
        t = mSpec[id];
        a = mAvail[id];
        for (int w = 0; w < NUM_WB; w++) begin
            if (wbValid[w] && wbTag[w] == t) begin
                a = 1'b1;
            end
        end
        // Older slot in the same bundle
        for (int j = 0; j < slot; j++) begin
            if (slotIssued[j] && dest[j] == id) begin
                t = slotTag[j];
                a = 1'b0;
            end
        end
    endfunction

    // One clock of the reference behaviour, evaluated before the edge
    function automatic void modelStep();
        logic [renamePkg::NUM_TAGS-1:0] taken;
        logic [renamePkg::NUM_TAGS-1:0] freed;
        logic st;
        renamePkg::tagT prev;
        renamePkg::tagT aTag;
        renamePkg::tagT bTag;
        logic aAv;
        logic bAv;
        freed = '0;
        st = modelStall();
        taken = mSpecUsed;
        for (int i = 0; i < WIDTH; i++) begin
            expCValid[i] = 1'b0;
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (qId.size() == 0 || !qDone[0]) begin
                break;
            end
            prev = mCom[qId[0]];
            expCValid[i] = 1'b1;
            expCommit[i] = {qId[0], qTag[0], prev};
            mCom[qId[0]] = qTag[0];
            mComUsed[qTag[0]] = 1'b1;
            if (prev != renamePkg::TAG_NONE) begin
                mComUsed[prev] = 1'b0;
                freed[prev] = 1'b1;
                freedSeen++;
            end
            void'(qId.pop_front());
            void'(qTag.pop_front());
            void'(qDone.pop_front());
        end
        for (int i = 0; i < WIDTH; i++) begin
            expValid[i] = instValid[i] && !st && !mispred;
            slotIssued[i] = expValid[i] && dest[i] != '0;
            slotTag[i] = renamePkg::TAG_NONE;
            lookupSrc(srcA[i], i, aTag, aAv);
            lookupSrc(srcB[i], i, bTag, bAv);
            if (slotIssued[i]) begin
                slotTag[i] = lowestFree(taken);
                taken[slotTag[i]] = 1'b1;
            end
            expRename[i] = {aTag, aAv, bTag, bAv, slotTag[i]};
        end
        for (int w = 0; w < NUM_WB; w++) begin
            if (wbValid[w] && wbId[w] != '0 && mSpec[wbId[w]] == wbTag[w]) begin
                mAvail[wbId[w]] = 1'b1;
            end
            for (int k = 0; k < qId.size(); k++) begin
                if (wbValid[w] && qTag[k] == wbTag[w]) begin
                    qDone[k] = 1'b1;
                end
            end
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (slotIssued[i]) begin
                mSpec[dest[i]] = slotTag[i];
                mAvail[dest[i]] = 1'b0;
                qId.push_back(dest[i]);
                qTag.push_back(slotTag[i]);
                qDone.push_back(1'b0);
            end
        end
        mSpecUsed = taken & ~freed;
        if (mispred) begin
            qId.delete();
            qTag.delete();
            qDone.delete();
            for (int r = 1; r < 32; r++) begin
                mSpec[r] = mCom[r];
                mAvail[r] = 1'b1;
            end
            mSpecUsed = mComUsed;
        end
    endfunction

    task automatic checkOutputs();
        for (int i = 0; i < WIDTH; i++) begin
            assert (outValid[i] === expValid[i]) else begin
                $display("ERROR %0t: slot %0d outValid %b, expected %b",
                         $time, i, outValid[i], expValid[i]);
                errors++;
            end
            if (expValid[i]) begin
                assert ({outSrcATag[i], outSrcAAvail[i], outSrcBTag[i], outSrcBAvail[i],
                         outDestTag[i]} === expRename[i]) else begin
                    $display("ERROR %0t: slot %0d rename %h, expected %h", $time, i,
                             {outSrcATag[i], outSrcAAvail[i], outSrcBTag[i],
                              outSrcBAvail[i], outDestTag[i]}, expRename[i]);
                    errors++;
                end
            end
            assert (commitValid[i] === expCValid[i]) else begin
                $display("ERROR %0t: slot %0d commitValid %b, expected %b",
                         $time, i, commitValid[i], expCValid[i]);
                errors++;
            end
            if (expCValid[i]) begin
                commitsSeen++;
                assert ({commitId[i], commitTag[i], commitPrevTag[i]} === expCommit[i])
                else begin
                    $display("ERROR %0t: slot %0d commit %h, expected %h", $time, i,
                             {commitId[i], commitTag[i], commitPrevTag[i]}, expCommit[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic driveInputs(int instPct, int wbPct, int mispPct);
        int k;
        for (int i = 0; i < WIDTH; i++) begin
            // Few registers, so bundles often depend on each other
            instValid[i] = pick(100) < instPct;
            srcA[i] = renamePkg::regIdT'(pick(8));
            srcB[i] = renamePkg::regIdT'(pick(8));
            dest[i] = renamePkg::regIdT'(pick(8));
        end
        for (int w = 0; w < NUM_WB; w++) begin
            wbValid[w] = 1'b0;
            wbId[w] = '0;
            wbTag[w] = '0;
            if (qId.size() > 0 && pick(100) < wbPct) begin
                k = pick(qId.size());
                wbValid[w] = 1'b1;
                wbId[w] = qId[k];
                wbTag[w] = qTag[k];
            end
        end
        mispred = pick(100) < mispPct;
    endtask

    task automatic runTest(string name, int length, int instPct, int wbPct, int mispPct);
        int startErrors;
        startErrors = errors;
        stallSeen = 0;
        freedSeen = 0;
        mispredSeen = 0;
        commitsSeen = 0;
        for (int c = 0; c < length; c++) begin
            @(posedge clk);
            #5;
            checkOutputs();
            driveInputs(instPct, wbPct, mispPct);
            @(negedge clk);
            assert (stall === modelStall()) else begin
                $display("ERROR %0t: stall %b, expected %b", $time, stall, modelStall());
                errors++;
            end
            stallSeen += stall;
            mispredSeen += mispred;
            modelStep();
        end
        testsRun++;
        if (errors != startErrors) begin
            testsFailed++;
        end
        $display("test %-10s %s, %0d errors, %0d commits, %0d stall cycles", name,
                 (errors == startErrors) ? "ok" : "failed", errors - startErrors,
                 commitsSeen, stallSeen);
    endtask

    initial begin
        rst = 1'b1;
        mispred = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            instValid[i] = 1'b0;
            srcA[i] = '0;
            srcB[i] = '0;
            dest[i] = '0;
            expValid[i] = 1'b0;
            expCValid[i] = 1'b0;
        end
        for (int w = 0; w < NUM_WB; w++) begin
            wbValid[w] = 1'b0;
            wbId[w] = '0;
            wbTag[w] = '0;
        end
        modelReset();
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        checkOutputs();
        assert (stall === 1'b0) else begin
            $display("ERROR %0t: stall high after reset", $time);
            errors++;
        end

        runTest("reset", 20, 50, 0, 0);
        runTest("random", 400, 70, 60, 0);
        runTest("alloc", 200, 60, 90, 0);
        if (freedSeen == 0) begin
            $display("No commit replaced an older tag, so tag reuse was never exercised");
            errors++;
        end
        runTest("commit", 150, 0, 100, 0);
        if (qId.size() != 0) begin
            $display("In-flight queue did not drain with every writeback enabled");
            errors++;
        end
        runTest("mispred", 300, 70, 40, 5);
        if (mispredSeen == 0) begin
            $display("No mispredict was driven during the mispredict test");
            errors++;
        end
        runTest("stall", 200, 90, 0, 0);
        if (stallSeen == 0) begin
            $display("Stall never asserted while the tracker filled up");
            errors++;
        end
        @(posedge clk);
        #5;
        checkOutputs();

        $display("%0d tests, %0d failed, %0d errors, %0d cycles",
                 testsRun, testsFailed, errors, cycles);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog/RenameUnit.sv */
`timescale 1ns/1ps

module RenameUnit #(
    parameter int WIDTH = 2,
    parameter int NUM_WB = 2,
    parameter int DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic mispred,

    input  logic instValid [WIDTH],
    input  renamePkg::regIdT srcA [WIDTH],
    input  renamePkg::regIdT srcB [WIDTH],
    input  renamePkg::regIdT dest [WIDTH],
    output logic stall,

    input  logic wbValid [NUM_WB],
    input  renamePkg::regIdT wbId [NUM_WB],
    input  renamePkg::tagT wbTag [NUM_WB],

    output logic outValid [WIDTH],
    output renamePkg::tagT outSrcATag [WIDTH],
    output logic outSrcAAvail [WIDTH],
    output renamePkg::tagT outSrcBTag [WIDTH],
    output logic outSrcBAvail [WIDTH],
    output renamePkg::tagT outDestTag [WIDTH],

    output logic commitValid [WIDTH],
    output renamePkg::regIdT commitId [WIDTH],
    output renamePkg::tagT commitTag [WIDTH],
    output renamePkg::tagT commitPrevTag [WIDTH]
);

    // Rename side
    renamePkg::regIdT lookupIds [2*WIDTH];
    logic lookupAvail [2*WIDTH];
    renamePkg::tagT lookupTags [2*WIDTH];
    logic issueValid [WIDTH];
    renamePkg::regIdT issueIds [WIDTH];
    renamePkg::tagT issueTags [WIDTH];
    logic issueAvail [WIDTH];
    logic allocReq [WIDTH];
    renamePkg::tagT allocTag [WIDTH];
    logic [$clog2(WIDTH+1)-1:0] freeCount;
    logic [$clog2(WIDTH+1)-1:0] trackerSpace;
    logic pushValid [WIDTH];
    renamePkg::regIdT pushId [WIDTH];
    renamePkg::tagT pushTag [WIDTH];

    // Commit side
    logic retireValid [WIDTH];
    renamePkg::regIdT retireIds [WIDTH];
    renamePkg::tagT retireTags [WIDTH];
    renamePkg::tagT retirePrevTags [WIDTH];
    logic freeValid [WIDTH];
    renamePkg::tagT freeTag [WIDTH];

    RenameStage #(.WIDTH(WIDTH)) stage (
        .clk(clk), .rst(rst), .mispred(mispred),
        .instValid(instValid), .srcA(srcA), .srcB(srcB), .dest(dest), .stall(stall),
        .lookupIds(lookupIds), .lookupAvail(lookupAvail), .lookupTags(lookupTags),
        .issueValid(issueValid), .issueIds(issueIds), .issueTags(issueTags),
        .issueAvail(issueAvail),
        .allocReq(allocReq), .allocTag(allocTag),
        .freeCount(freeCount), .trackerSpace(trackerSpace),
        .pushValid(pushValid), .pushId(pushId), .pushTag(pushTag),
        .outValid(outValid), .outSrcATag(outSrcATag), .outSrcAAvail(outSrcAAvail),
        .outSrcBTag(outSrcBTag), .outSrcBAvail(outSrcBAvail), .outDestTag(outDestTag)
    );

    RenameTable #(.WIDTH(WIDTH), .NUM_WB(NUM_WB)) table0 (
        .clk(clk), .rst(rst), .mispred(mispred),
        .lookupIds(lookupIds), .lookupAvail(lookupAvail), .lookupTags(lookupTags),
        .issueValid(issueValid), .issueIds(issueIds), .issueTags(issueTags),
        .issueAvail(issueAvail),
        .commitValid(retireValid), .commitIds(retireIds), .commitTags(retireTags),
        .commitPrevTags(retirePrevTags),
        .wbValid(wbValid), .wbId(wbId), .wbTag(wbTag)
    );

    TagFreeList #(.WIDTH(WIDTH)) freeList (
        .clk(clk), .rst(rst), .mispred(mispred),
        .allocReq(allocReq), .allocTag(allocTag), .freeCount(freeCount),
        .commitValid(retireValid), .commitTag(retireTags),
        .freeValid(freeValid), .freeTag(freeTag)
    );

    CommitTracker #(.WIDTH(WIDTH), .NUM_WB(NUM_WB), .DEPTH(DEPTH)) tracker (
        .clk(clk), .rst(rst), .mispred(mispred),
        .pushValid(pushValid), .pushId(pushId), .pushTag(pushTag),
        .trackerSpace(trackerSpace),
        .wbValid(wbValid), .wbTag(wbTag),
        .commitReq(retireValid), .commitIds(retireIds), .commitTags(retireTags),
        .commitPrevTags(retirePrevTags),
        .freeValid(freeValid), .freeTag(freeTag),
        .commitValid(commitValid), .commitId(commitId), .commitTag(commitTag),
        .commitPrevTag(commitPrevTag)
    );

endmodule

/* verilog/CommitTracker.sv */
`timescale 1ns/1ps

module CommitTracker #(
    parameter int WIDTH = 2,
    parameter int NUM_WB = 2,
    parameter int DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic mispred,

    input  logic pushValid [WIDTH],
    input  renamePkg::regIdT pushId [WIDTH],
    input  renamePkg::tagT pushTag [WIDTH],
    output logic [$clog2(WIDTH+1)-1:0] trackerSpace,

    input  logic wbValid [NUM_WB],
    input  renamePkg::tagT wbTag [NUM_WB],

    // Table side of the commit, same cycle
    output logic commitReq [WIDTH],
    output renamePkg::regIdT commitIds [WIDTH],
    output renamePkg::tagT commitTags [WIDTH],
    input  renamePkg::tagT commitPrevTags [WIDTH],

    output logic freeValid [WIDTH],
    output renamePkg::tagT freeTag [WIDTH],

    // Registered commit report
    output logic commitValid [WIDTH],
    output renamePkg::regIdT commitId [WIDTH],
    output renamePkg::tagT commitTag [WIDTH],
    output renamePkg::tagT commitPrevTag [WIDTH]
);

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;

    renamePkg::regIdT entryId [DEPTH];
    renamePkg::tagT entryTag [DEPTH];
    logic [DEPTH-1:0] entryDone;

    // Extra bit tells full from empty
    logic [CNT_BITS-1:0] head;
    logic [CNT_BITS-1:0] tail;
    logic [CNT_BITS-1:0] used;
    logic [CNT_BITS-1:0] spaceLeft;
    logic [CNT_BITS-1:0] commitCount;
    logic [CNT_BITS-1:0] pushCount;
    logic [PTR_BITS-1:0] pushSlot [WIDTH];
    logic [PTR_BITS-1:0] headSlot [WIDTH];

    assign used = tail - head;
    assign spaceLeft = CNT_BITS'(DEPTH) - used;
    assign trackerSpace = (spaceLeft >= WIDTH) ? ($bits(trackerSpace))'(WIDTH)
                                               : ($bits(trackerSpace))'(spaceLeft);

    // Consecutive done entries from the head
    always_comb begin : retire
        logic chain;
        chain = 1'b1;
        commitCount = '0;
        for (int i = 0; i < WIDTH; i++) begin
            headSlot[i] = head[PTR_BITS-1:0] + PTR_BITS'(i);
            commitReq[i] = chain && used > CNT_BITS'(i) && entryDone[headSlot[i]];
            chain = commitReq[i];
            commitIds[i] = entryId[headSlot[i]];
            commitTags[i] = entryTag[headSlot[i]];
            freeValid[i] = commitReq[i] && commitPrevTags[i] != renamePkg::TAG_NONE;
            freeTag[i] = commitPrevTags[i];
            if (commitReq[i]) begin
                commitCount = commitCount + 1'b1;
            end
        end
    end

    // Pack pushes behind the tail
    always_comb begin
        pushCount = '0;
        for (int i = 0; i < WIDTH; i++) begin
            pushSlot[i] = tail[PTR_BITS-1:0] + pushCount[PTR_BITS-1:0];
            if (pushValid[i]) begin
                pushCount = pushCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= head + commitCount;
            tail <= tail + pushCount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryDone <= '0;
        end else begin
            // Tags are unique while in flight
            for (int e = 0; e < DEPTH; e++) begin
                for (int w = 0; w < NUM_WB; w++) begin
                    if (wbValid[w] && entryTag[e] == wbTag[w]) begin
                        entryDone[e] <= 1'b1;
                    end
                end
            end
            for (int i = 0; i < WIDTH; i++) begin
                if (pushValid[i]) begin
                    entryDone[pushSlot[i]] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (pushValid[i]) begin
                entryId[pushSlot[i]] <= pushId[i];
                entryTag[pushSlot[i]] <= pushTag[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            commitValid[i] <= rst ? 1'b0 : commitReq[i];
            commitId[i] <= commitIds[i];
            commitTag[i] <= commitTags[i];
            commitPrevTag[i] <= commitPrevTags[i];
        end
    end

endmodule

/* verilog/RenameStage.sv */
`timescale 1ns/1ps

module RenameStage #(
    parameter int WIDTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic mispred,

    input  logic instValid [WIDTH],
    input  renamePkg::regIdT srcA [WIDTH],
    input  renamePkg::regIdT srcB [WIDTH],
    input  renamePkg::regIdT dest [WIDTH],
    output logic stall,

    output renamePkg::regIdT lookupIds [2*WIDTH],
    input  logic lookupAvail [2*WIDTH],
    input  renamePkg::tagT lookupTags [2*WIDTH],

    output logic issueValid [WIDTH],
    output renamePkg::regIdT issueIds [WIDTH],
    output renamePkg::tagT issueTags [WIDTH],
    output logic issueAvail [WIDTH],

    output logic allocReq [WIDTH],
    input  renamePkg::tagT allocTag [WIDTH],
    input  logic [$clog2(WIDTH+1)-1:0] freeCount,
    input  logic [$clog2(WIDTH+1)-1:0] trackerSpace,

    output logic pushValid [WIDTH],
    output renamePkg::regIdT pushId [WIDTH],
    output renamePkg::tagT pushTag [WIDTH],

    output logic outValid [WIDTH],
    output renamePkg::tagT outSrcATag [WIDTH],
    output logic outSrcAAvail [WIDTH],
    output renamePkg::tagT outSrcBTag [WIDTH],
    output logic outSrcBAvail [WIDTH],
    output renamePkg::tagT outDestTag [WIDTH]
);

    logic accept [WIDTH];
    logic needTag [WIDTH];

    // Need room for a full bundle in both the free list and the tracker
    assign stall = (freeCount < WIDTH) || (trackerSpace < WIDTH);

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            accept[i] = instValid[i] && !stall && !mispred;
            // Register 0 is never renamed
            needTag[i] = accept[i] && dest[i] != '0;

            lookupIds[2*i] = srcA[i];
            lookupIds[2*i+1] = srcB[i];

            allocReq[i] = needTag[i];
            issueValid[i] = needTag[i];
            issueIds[i] = dest[i];
            issueTags[i] = allocTag[i];
            issueAvail[i] = 1'b0;

            // Only real destinations wait in the tracker
            pushValid[i] = needTag[i];
            pushId[i] = dest[i];
            pushTag[i] = allocTag[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            outValid[i] <= rst ? 1'b0 : accept[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            outSrcATag[i] <= lookupTags[2*i];
            outSrcAAvail[i] <= lookupAvail[2*i];
            outSrcBTag[i] <= lookupTags[2*i+1];
            outSrcBAvail[i] <= lookupAvail[2*i+1];
            outDestTag[i] <= needTag[i] ? allocTag[i] : renamePkg::TAG_NONE;
        end
    end

endmodule

/* renameTable/TagFreeList.sv */
`timescale 1ns/1ps

module TagFreeList #(
    parameter int WIDTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic mispred,

    input  logic allocReq [WIDTH],
    output renamePkg::tagT allocTag [WIDTH],
    output logic [$clog2(WIDTH+1)-1:0] freeCount,

    // Tags becoming committed mappings
    input  logic commitValid [WIDTH],
    input  renamePkg::tagT commitTag [WIDTH],

    // Tags displaced by commits
    input  logic freeValid [WIDTH],
    input  renamePkg::tagT freeTag [WIDTH]
);

    localparam int N = renamePkg::NUM_TAGS;

    logic [N-1:0] specUsed;
    logic [N-1:0] comUsed;
    logic [N-1:0] allocMask;
    logic [N-1:0] commitMask;
    logic [N-1:0] freeMask;
    logic [N-1:0] comNext;

    // Lowest free tags in slot order
    always_comb begin : allocSearch
        logic [N-1:0] taken;
        logic found;
        taken = specUsed;
        for (int i = 0; i < WIDTH; i++) begin
            allocTag[i] = renamePkg::TAG_NONE;
            found = 1'b0;
            for (int t = 0; t < N; t++) begin
                if (!found && !taken[t]) begin
                    allocTag[i] = renamePkg::tagT'(t);
                    found = 1'b1;
                end
            end
            if (allocReq[i] && found) begin
                taken[allocTag[i]] = 1'b1;
            end
        end
        allocMask = taken & ~specUsed;
    end

    // Count only up to what one bundle can take
    always_comb begin
        freeCount = '0;
        for (int t = 0; t < N; t++) begin
            if (!specUsed[t] && freeCount < WIDTH) begin
                freeCount = freeCount + 1'b1;
            end
        end
    end

    always_comb begin
        commitMask = '0;
        freeMask = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (commitValid[i]) begin
                commitMask[commitTag[i]] = 1'b1;
            end
            if (freeValid[i] && freeTag[i] != renamePkg::TAG_NONE) begin
                freeMask[freeTag[i]] = 1'b1;
            end
        end
        // Free after set, so a tag committed and replaced in one cycle ends up free
        comNext = (comUsed | commitMask) & ~freeMask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            specUsed <= '0;
            comUsed <= '0;
            specUsed[renamePkg::TAG_NONE] <= 1'b1;
            comUsed[renamePkg::TAG_NONE] <= 1'b1;
        end else begin
            comUsed <= comNext;
            if (mispred) begin
                specUsed <= comNext;
            end else begin
                specUsed <= (specUsed | allocMask) & ~freeMask;
            end
        end
    end

endmodule

/* renameTable/RenameTable.sv */
`timescale 1ns/1ps

module RenameTable #(
    parameter int WIDTH = 2,
    parameter int NUM_WB = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic mispred,

    // Source lookups, two per slot
    input  renamePkg::regIdT lookupIds [2*WIDTH],
    output logic lookupAvail [2*WIDTH],
    output renamePkg::tagT lookupTags [2*WIDTH],

    // New speculative mappings from rename
    input  logic issueValid [WIDTH],
    input  renamePkg::regIdT issueIds [WIDTH],
    input  renamePkg::tagT issueTags [WIDTH],
    input  logic issueAvail [WIDTH],

    // In-order commits from the tracker
    input  logic commitValid [WIDTH],
    input  renamePkg::regIdT commitIds [WIDTH],
    input  renamePkg::tagT commitTags [WIDTH],
    output renamePkg::tagT commitPrevTags [WIDTH],

    input  logic wbValid [NUM_WB],
    input  renamePkg::regIdT wbId [NUM_WB],
    input  renamePkg::tagT wbTag [NUM_WB]
);

    localparam int NUM_REGS = 2 ** renamePkg::ID_SIZE;

    renamePkg::RatEntry rat [NUM_REGS];

    always_comb begin
        for (int i = 0; i < 2 * WIDTH; i++) begin
            lookupAvail[i] = rat[lookupIds[i]].avail;
            lookupTags[i] = rat[lookupIds[i]].specTag;

            // Results written back this cycle are ready too
            for (int w = 0; w < NUM_WB; w++) begin
                if (wbValid[w] && wbTag[w] == rat[lookupIds[i]].specTag) begin
                    lookupAvail[i] = 1'b1;
                end
            end

            // Earlier slots of the same bundle win, the latest one last
            for (int j = 0; j < i / 2; j++) begin
                if (issueValid[j] && issueIds[j] != '0 && issueIds[j] == lookupIds[i]) begin
                    lookupAvail[i] = issueAvail[j];
                    lookupTags[i] = issueTags[j];
                end
            end
        end
    end

    // Mapping replaced by each commit
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            commitPrevTags[i] = rat[commitIds[i]].comTag;
            // An older commit to the same register in this cycle
            for (int j = 0; j < i; j++) begin
                if (commitValid[j] && commitIds[j] == commitIds[i]) begin
                    commitPrevTags[i] = commitTags[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                rat[r] <= '{
                    avail: 1'b1,
                    comTag: renamePkg::TAG_NONE,
                    specTag: renamePkg::TAG_NONE
                };
            end
        end else begin
            // Only the current speculative tag may become ready
            for (int w = 0; w < NUM_WB; w++) begin
                if (wbValid[w] && wbId[w] != '0 && rat[wbId[w]].specTag == wbTag[w]) begin
                    rat[wbId[w]].avail <= 1'b1;
                end
            end

            if (mispred) begin
                // Squash everything in flight
                for (int r = 1; r < NUM_REGS; r++) begin
                    rat[r].avail <= 1'b1;
                    rat[r].specTag <= rat[r].comTag;
                end
            end else begin
                for (int i = 0; i < WIDTH; i++) begin
                    if (issueValid[i] && issueIds[i] != '0) begin
                        rat[issueIds[i]].avail <= issueAvail[i];
                        rat[issueIds[i]].specTag <= issueTags[i];
                    end
                end
            end

            // Commits land even on a mispredict edge
            for (int i = 0; i < WIDTH; i++) begin
                if (commitValid[i] && commitIds[i] != '0) begin
                    rat[commitIds[i]].comTag <= commitTags[i];
                    if (mispred) begin
                        rat[commitIds[i]].specTag <= commitTags[i];
                    end
                end
            end
        end
    end

endmodule

/* common/renamePkg.sv */
package renamePkg;

    // Register and tag widths
    localparam int ID_SIZE = 5;
    localparam int TAG_SIZE = 7;
    localparam int NUM_TAGS = 2 ** TAG_SIZE;

    typedef logic [ID_SIZE-1:0] regIdT;
    typedef logic [TAG_SIZE-1:0] tagT;

    // Value lives in the architectural file, never handed out
    localparam tagT TAG_NONE = tagT'(NUM_TAGS - 1);

    // One alias table entry per architectural register
    typedef struct packed {
        logic avail;
        tagT comTag;
        tagT specTag;
    } RatEntry;

endpackage
